/* sim.f */
backend_pkg.sv
result_if.sv
issue_stage.sv
alu_unit.sv
mul_unit.sv
reorder_buffer.sv
back_end_top.sv
tb_back_end.sv

/* Bender.yml */
package:
  name: back_end

sources:
  - backend_pkg.sv
  - result_if.sv
  - issue_stage.sv
  - alu_unit.sv
  - mul_unit.sv
  - reorder_buffer.sv
  - back_end_top.sv
  - target: test
    files:
      - tb_back_end.sv

/* tb_back_end.sv */
// Back end self-checking testbench
module tb_back_end;

    import backend_pkg::*;

    // ============================================================
    // Stimulus table
    // ============================================================

    // Columns: operation, sources, destination, address, then five flags
    // rnd    source 1 is register 0 and carries a fresh LFSR word instead
    // drain  wait for an empty pipeline before the next row
    // exc    the row raises the exception and never writes back
    // squash the row is younger than a fault and never writes back
    // stall  the row has to see stall_o at least once while offered
    typedef struct packed {
        op_t        op;
        reg_addr_t  src0;
        reg_addr_t  src1;
        reg_addr_t  dest;
        data_word_t addr;
        bit         rnd;
        bit         drain;
        bit         exc;
        bit         squash;
        bit         stall;
    } stim_row_t;

    localparam int NUM_ROWS    = 35;
    localparam int CYCLE_LIMIT = 40 * NUM_ROWS + 200;

    localparam stim_row_t ROWS [NUM_ROWS] = '{
        // Random values loaded into r1 to r4
        '{OP_ADD, 5'd0,  5'd0,  5'd1,  32'h0000_0100, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_ADD, 5'd0,  5'd0,  5'd2,  32'h0000_0104, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_ADD, 5'd0,  5'd0,  5'd3,  32'h0000_0108, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_ADD, 5'd0,  5'd0,  5'd4,  32'h0000_010c, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
        // Every ALU operation once
        '{OP_ADD, 5'd1,  5'd2,  5'd5,  32'h0000_0110, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_SUB, 5'd3,  5'd1,  5'd6,  32'h0000_0114, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_AND, 5'd2,  5'd4,  5'd7,  32'h0000_0118, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_OR,  5'd1,  5'd3,  5'd8,  32'h0000_011c, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_XOR, 5'd2,  5'd4,  5'd9,  32'h0000_0120, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_SLL, 5'd1,  5'd3,  5'd10, 32'h0000_0124, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        // A multiply overtaken by younger ALU results
        '{OP_MUL, 5'd1,  5'd2,  5'd11, 32'h0000_0128, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_ADD, 5'd3,  5'd4,  5'd12, 32'h0000_012c, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_XOR, 5'd5,  5'd6,  5'd13, 32'h0000_0130, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_SUB, 5'd7,  5'd8,  5'd14, 32'h0000_0134, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        // Read-after-write chain through both units
        '{OP_ADD, 5'd11, 5'd1,  5'd15, 32'h0000_0138, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_MUL, 5'd15, 5'd2,  5'd16, 32'h0000_013c, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1},
        '{OP_ADD, 5'd16, 5'd3,  5'd17, 32'h0000_0140, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1},
        '{OP_SLL, 5'd17, 5'd4,  5'd18, 32'h0000_0144, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1},
        '{OP_MUL, 5'd18, 5'd18, 5'd19, 32'h0000_0148, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1},
        '{OP_SUB, 5'd19, 5'd17, 5'd20, 32'h0000_014c, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1},
        // Illegal operation with two younger instructions behind it
        '{OP_ILLEGAL, 5'd1, 5'd2, 5'd21, 32'h0000_0150, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0},
        '{OP_ADD, 5'd1,  5'd2,  5'd22, 32'h0000_0154, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
        '{OP_OR,  5'd3,  5'd4,  5'd23, 32'h0000_0158, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0},
        // Work after the flush reads registers the squashed rows never wrote
        '{OP_ADD, 5'd22, 5'd5,  5'd24, 32'h0000_015c, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_XOR, 5'd24, 5'd23, 5'd25, 32'h0000_0160, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1},
        // Nine multiplies back to back behind one producer
        '{OP_MUL, 5'd1,  5'd3,  5'd26, 32'h0000_0164, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_MUL, 5'd26, 5'd2,  5'd27, 32'h0000_0168, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1},
        '{OP_MUL, 5'd26, 5'd4,  5'd28, 32'h0000_016c, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_MUL, 5'd26, 5'd5,  5'd29, 32'h0000_0170, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_MUL, 5'd26, 5'd6,  5'd30, 32'h0000_0174, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_MUL, 5'd26, 5'd7,  5'd31, 32'h0000_0178, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_MUL, 5'd26, 5'd8,  5'd1,  32'h0000_017c, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_MUL, 5'd26, 5'd9,  5'd2,  32'h0000_0180, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_MUL, 5'd26, 5'd10, 5'd3,  32'h0000_0184, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0},
        '{OP_MUL, 5'd26, 5'd12, 5'd4,  32'h0000_0188, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0}
    };

    // One accepted instruction waiting for its writeback or exception
    typedef struct {
        int         row;
        op_t        op;
        reg_addr_t  src0;
        reg_addr_t  src1;
        reg_addr_t  dest;
        data_word_t imm;
        data_word_t addr;
    } inflight_t;

    logic             clk;
    logic             rst_n;
    logic             issue_valid;
    op_t              issue_op;
    reg_addr_t [1:0]  reg_src;
    data_word_t [1:0] operand;
    reg_addr_t        reg_dest;
    data_word_t       instr_addr;
    logic             stall_o;
    logic             writeback_o;
    reg_addr_t        reg_destination_o;
    data_word_t       writeback_result_o;
    logic             exception_o;
    data_word_t       exception_addr_o;
    logic             flush_o;
    logic             pipeline_empty_o;

    data_word_t  gold_regs [32];
    inflight_t   inflight_q [$];
    int          wb_count [NUM_ROWS];
    int          exc_count [NUM_ROWS];
    bit          stall_seen [NUM_ROWS];
    logic [31:0] lfsr_state = 32'h708d;

    back_end_top u_back_end_top (
        .clk_i              (clk),
        .rst_n_i            (rst_n),
        .issue_valid_i      (issue_valid),
        .issue_op_i         (issue_op),
        .reg_src_i          (reg_src),
        .operand_i          (operand),
        .reg_dest_i         (reg_dest),
        .instr_addr_i       (instr_addr),
        .stall_o            (stall_o),
        .writeback_o        (writeback_o),
        .reg_destination_o  (reg_destination_o),
        .writeback_result_o (writeback_result_o),
        .exception_o        (exception_o),
        .exception_addr_o   (exception_addr_o),
        .flush_o            (flush_o),
        .pipeline_empty_o   (pipeline_empty_o)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #10 clk = ~clk;
    end : clock_gen

    // ============================================================
    // Checks and golden model
    // ============================================================

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input data_word_t got,
                              input data_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    function automatic bit count_matches(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    // Register 0 stands for the immediate that rides on the operand bus
    function automatic data_word_t operand_value(input reg_addr_t r, input data_word_t imm);
        return (r == '0) ? imm : gold_regs[r];
    endfunction

    function automatic data_word_t expected_result(input op_t op, input data_word_t a,
                                                   input data_word_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_MUL:  return a * b;
            default: return '0;
        endcase
    endfunction

    // Taps 32, 22, 2 and 1 give a maximal length sequence
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_word(output data_word_t w);
        w = '0;
        for (int b = 0; b < XLEN; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[XLEN-2:0], lfsr_state[0]};
        end
    endtask

    // Older instructions have all retired, so the golden file is exact for this one
    task automatic retire_head();
        inflight_t  e;
        data_word_t exp;
        if (inflight_q.size() == 0) begin
            abort_run("A writeback appeared while no instruction was in flight");
        end
        e   = inflight_q.pop_front();
        exp = expected_result(e.op, operand_value(e.src0, '0), operand_value(e.src1, e.imm));
        check_flag("flush_o", flush_o, 1'b0);
        check_reg("reg_destination_o", reg_destination_o, e.dest);
        check_word("writeback_result_o", writeback_result_o, exp);
        if (e.dest != '0) begin
            gold_regs[e.dest] = exp;
        end
        wb_count[e.row]++;
    endtask

    // Everything behind the faulting head is thrown away
    task automatic take_exception();
        if (inflight_q.size() == 0) begin
            abort_run("An exception appeared while no instruction was in flight");
        end
        check_flag("flush_o", flush_o, 1'b1);
        check_word("exception_addr_o", exception_addr_o, inflight_q[0].addr);
        exc_count[inflight_q[0].row]++;
        inflight_q.delete();
    endtask

    // ============================================================
    // Driving and sampling
    // ============================================================

    task automatic drive_row(input int i, input data_word_t imm);
        issue_valid = 1'b1;
        issue_op    = ROWS[i].op;
        reg_src[0]  = ROWS[i].src0;
        reg_src[1]  = ROWS[i].src1;
        operand[0]  = operand_value(ROWS[i].src0, '0);
        operand[1]  = operand_value(ROWS[i].src1, imm);
        reg_dest    = ROWS[i].dest;
        instr_addr  = ROWS[i].addr;
    endtask

    // Outputs have been settled since the falling edge, nothing inside the DUT moved yet
    task automatic observe_edge(input bit offered, input int row, input data_word_t imm,
                                output bit taken);
        inflight_t e;
        @(posedge clk);
        if (offered && stall_o) begin
            stall_seen[row] = 1'b1;
        end
        if (writeback_o) begin
            retire_head();
        end
        if (exception_o) begin
            take_exception();
        end
        // An instruction offered on the flush edge is dropped with the younger ones
        taken = offered && !stall_o && !flush_o;
        if (taken) begin
            e.row  = row;
            e.op   = ROWS[row].op;
            e.src0 = ROWS[row].src0;
            e.src1 = ROWS[row].src1;
            e.dest = ROWS[row].dest;
            e.imm  = imm;
            e.addr = ROWS[row].addr;
            inflight_q.push_back(e);
        end
    endtask

    // Called on a falling edge and returns on one, after every issued instruction is gone
    task automatic wait_until_empty();
        bit taken;
        issue_valid = 1'b0;
        while (inflight_q.size() != 0) begin
            observe_edge(1'b0, 0, '0, taken);
            @(negedge clk);
        end
        check_flag("pipeline_empty_o", pipeline_empty_o, 1'b1);
    endtask

    initial begin : timeout_guard
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        abort_run($sformatf("Timeout, the run did not end within %0d cycles", CYCLE_LIMIT));
    end : timeout_guard

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin : stimulus
        data_word_t imm;
        bit         taken;
        bit         done;
        bit         ok;
        rst_n       = 1'b0;
        issue_valid = 1'b0;
        issue_op    = OP_ADD;
        reg_src     = '0;
        operand     = '0;
        reg_dest    = '0;
        instr_addr  = '0;
        foreach (gold_regs[r]) begin
            gold_regs[r] = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_flag("stall_o", stall_o, 1'b0);
        check_flag("writeback_o", writeback_o, 1'b0);
        check_flag("exception_o", exception_o, 1'b0);
        check_flag("flush_o", flush_o, 1'b0);
        check_flag("pipeline_empty_o", pipeline_empty_o, 1'b1);
        rst_n = 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            imm = '0;
            if (ROWS[i].rnd) begin
                draw_word(imm);
            end
            // Operands are driven again each cycle since retirement may change them
            done = 1'b0;
            while (!done) begin
                drive_row(i, imm);
                observe_edge(1'b1, i, imm, taken);
                done = taken || (flush_o && ROWS[i].squash);
                @(negedge clk);
            end
            if (ROWS[i].drain) begin
                wait_until_empty();
            end
        end
        wait_until_empty();

        // Each row retires once, faults once, or vanishes, as its flags say
        ok = 1'b1;
        for (int i = 0; i < NUM_ROWS && ok; i++) begin
            ok = count_matches($sformatf("writebacks of row %0d", i), wb_count[i],
                               (ROWS[i].exc || ROWS[i].squash) ? 0 : 1);
            if (ok) begin
                ok = count_matches($sformatf("exceptions of row %0d", i), exc_count[i],
                                   int'(ROWS[i].exc));
            end
            if (ok && ROWS[i].stall) begin
                ok = count_matches($sformatf("stall seen by row %0d", i),
                                   int'(stall_seen[i]), 1);
            end
        end

        if (ok) begin
            $display("Verification passed");
            $finish;
        end else begin
            abort_run("Instruction accounting at the end of the run does not match the table");
        end
    end : stimulus

endmodule : tb_back_end

/* back_end_top.sv */
// Out-of-order back end top level
module back_end_top (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          issue_valid_i,
    input  backend_pkg::op_t              issue_op_i,
    input  backend_pkg::reg_addr_t [1:0]  reg_src_i,
    input  backend_pkg::data_word_t [1:0] operand_i,
    input  backend_pkg::reg_addr_t        reg_dest_i,
    input  backend_pkg::data_word_t       instr_addr_i,
    output logic                          stall_o,
    output logic                          writeback_o,
    output backend_pkg::reg_addr_t        reg_destination_o,
    output backend_pkg::data_word_t       writeback_result_o,
    output logic                          exception_o,
    output backend_pkg::data_word_t       exception_addr_o,
    output logic                          flush_o,
    output logic                          pipeline_empty_o
);

    import backend_pkg::*;

    reg_addr_t [1:0]  fwd_src;
    logic [1:0]       fwd_hit;
    logic [1:0]       fwd_done;
    data_word_t [1:0] fwd_data;
    logic             rob_full;
    rob_tag_t         alloc_tag;
    logic             accept;
    issue_pkt_t       alu_pkt;
    issue_pkt_t       mul_pkt;

    // One result channel per execution unit
    result_if alu_res_if ();
    result_if mul_res_if ();

    // ============================================================
    // Issue and execution
    // ============================================================

    issue_stage u_issue_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_o),
        .issue_valid_i  (issue_valid_i),
        .issue_op_i     (issue_op_i),
        .reg_src_i      (reg_src_i),
        .operand_i      (operand_i),
        .rob_fwd_hit_i  (fwd_hit),
        .rob_fwd_done_i (fwd_done),
        .rob_fwd_data_i (fwd_data),
        .rob_full_i     (rob_full),
        .alloc_tag_i    (alloc_tag),
        .fwd_src_o      (fwd_src),
        .accept_o       (accept),
        .stall_o        (stall_o),
        .alu_pkt_o      (alu_pkt),
        .mul_pkt_o      (mul_pkt)
    );

    alu_unit u_alu_unit (
        .pkt_i (alu_pkt),
        .res   (alu_res_if.producer)
    );

    mul_unit u_mul_unit (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_o),
        .pkt_i   (mul_pkt),
        .res     (mul_res_if.producer)
    );

    // ============================================================
    // Reorder buffer and retirement
    // ============================================================

    reorder_buffer u_reorder_buffer (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .alloc_i            (accept),
        .alloc_dest_i       (reg_dest_i),
        .alloc_addr_i       (instr_addr_i),
        .fwd_src_i          (fwd_src),
        .alu_res            (alu_res_if.consumer),
        .mul_res            (mul_res_if.consumer),
        .alloc_tag_o        (alloc_tag),
        .full_o             (rob_full),
        .empty_o            (pipeline_empty_o),
        .fwd_hit_o          (fwd_hit),
        .fwd_done_o         (fwd_done),
        .fwd_data_o         (fwd_data),
        .writeback_o        (writeback_o),
        .reg_destination_o  (reg_destination_o),
        .writeback_result_o (writeback_result_o),
        .exception_o        (exception_o),
        .exception_addr_o   (exception_addr_o),
        .flush_o            (flush_o)
    );

endmodule : back_end_top

/* reorder_buffer.sv */
// Reorder buffer with in-order retirement
module reorder_buffer (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          alloc_i,
    input  backend_pkg::reg_addr_t        alloc_dest_i,
    input  backend_pkg::data_word_t       alloc_addr_i,
    input  backend_pkg::reg_addr_t [1:0]  fwd_src_i,
    result_if.consumer                    alu_res,
    result_if.consumer                    mul_res,
    output backend_pkg::rob_tag_t         alloc_tag_o,
    output logic                          full_o,
    output logic                          empty_o,
    output logic [1:0]                    fwd_hit_o,
    output logic [1:0]                    fwd_done_o,
    output backend_pkg::data_word_t [1:0] fwd_data_o,
    output logic                          writeback_o,
    output backend_pkg::reg_addr_t        reg_destination_o,
    output backend_pkg::data_word_t       writeback_result_o,
    output logic                          exception_o,
    output backend_pkg::data_word_t       exception_addr_o,
    output logic                          flush_o
);

    import backend_pkg::*;

    rob_entry_t                   rob_q [ROB_DEPTH];
    rob_entry_t                   head_entry;
    rob_tag_t                     head_q;
    rob_tag_t                     tail_q;
    logic [$clog2(ROB_DEPTH):0]   count_q;

    assign alloc_tag_o = tail_q;
    assign full_o      = (count_q == ROB_DEPTH);
    assign empty_o     = (count_q == '0);

    // ============================================================
    // Forwarding lookup
    // ============================================================

    // Walk back from the newest entry so the youngest producer of a register is found first
    always_comb begin : forward_lookup
        rob_tag_t idx;
        logic     found;
        fwd_hit_o  = '0;
        fwd_done_o = '0;
        fwd_data_o = '0;
        for (int s = 0; s < 2; s++) begin
            found = 1'b0;
            for (int i = 1; i <= ROB_DEPTH; i++) begin
                idx = tail_q - rob_tag_t'(i);
                if (!found && rob_q[idx].valid && (fwd_src_i[s] != '0) &&
                    (rob_q[idx].reg_dest == fwd_src_i[s])) begin
                    found         = 1'b1;
                    fwd_hit_o[s]  = 1'b1;
                    fwd_done_o[s] = rob_q[idx].done;
                    fwd_data_o[s] = rob_q[idx].result;
                end
            end
        end
    end : forward_lookup

    // ============================================================
    // Retirement
    // ============================================================

    assign head_entry = rob_q[head_q];

    // A finished head either writes back or, if it faulted, squashes everything younger
    assign writeback_o        = head_entry.valid & head_entry.done & ~head_entry.exception;
    assign exception_o        = head_entry.valid & head_entry.done & head_entry.exception;
    assign flush_o            = exception_o;
    assign reg_destination_o  = head_entry.reg_dest;
    assign writeback_result_o = head_entry.result;
    assign exception_addr_o   = head_entry.instr_addr;

    always_ff @(posedge clk_i) begin : rob_update
        if (!rst_n_i || exception_o) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                rob_q[i].valid <= 1'b0;
            end
        end else begin
            // New entry waits at the tail until its unit reports back
            if (alloc_i) begin
                rob_q[tail_q].valid      <= 1'b1;
                rob_q[tail_q].done       <= 1'b0;
                rob_q[tail_q].exception  <= 1'b0;
                rob_q[tail_q].reg_dest   <= alloc_dest_i;
                rob_q[tail_q].instr_addr <= alloc_addr_i;
                tail_q                   <= tail_q + 1'b1;
            end
            // Both units may finish in the same cycle since their tags always differ
            if (alu_res.valid) begin
                rob_q[alu_res.tag].done      <= 1'b1;
                rob_q[alu_res.tag].result    <= alu_res.result;
                rob_q[alu_res.tag].exception <= alu_res.exception;
            end
            if (mul_res.valid) begin
                rob_q[mul_res.tag].done      <= 1'b1;
                rob_q[mul_res.tag].result    <= mul_res.result;
                rob_q[mul_res.tag].exception <= mul_res.exception;
            end
            if (writeback_o) begin
                rob_q[head_q].valid <= 1'b0;
                head_q              <= head_q + 1'b1;
            end
            case ({alloc_i, writeback_o})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end : rob_update

    // Results may only land on entries that were allocated and are still waiting
    a_alu_write_live : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alu_res.valid |-> (rob_q[alu_res.tag].valid && !rob_q[alu_res.tag].done));
    a_mul_write_live : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mul_res.valid |-> (rob_q[mul_res.tag].valid && !rob_q[mul_res.tag].done));

    // The issue stage has to hold instructions back while every entry is taken
    a_no_alloc_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alloc_i |-> !full_o);

endmodule : reorder_buffer

/* mul_unit.sv */
// Pipelined multiplier
module mul_unit (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  backend_pkg::issue_pkt_t pkt_i,
    result_if.producer              res
);

    import backend_pkg::*;

    // Stage 1 holds the two partial products, stage 2 the summed low word
    logic        s1_valid;
    rob_tag_t    s1_tag;
    data_word_t  s1_pp_lo;
    logic [15:0] s1_pp_hi;
    logic        s2_valid;
    rob_tag_t    s2_tag;
    data_word_t  s2_prod;

    // A flush drops every product in flight
    always_ff @(posedge clk_i) begin : stage_valid
        if (!rst_n_i || flush_i) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= pkt_i.valid;
            s2_valid <= s1_valid;
        end
    end : stage_valid

    // The upper half of operand 1 only reaches the low word through bits 31:16
    always_ff @(posedge clk_i) begin : stage_data
        s1_tag   <= pkt_i.tag;
        s1_pp_lo <= pkt_i.operand[0] * pkt_i.operand[1][15:0];
        s1_pp_hi <= pkt_i.operand[0][15:0] * pkt_i.operand[1][31:16];
        s2_tag   <= s1_tag;
        s2_prod  <= s1_pp_lo + {s1_pp_hi, 16'h0000};
    end : stage_data

    // Third stage drives the buffer write port straight from stage 2
    assign res.valid     = s2_valid;
    assign res.tag       = s2_tag;
    assign res.result    = s2_prod;
    assign res.exception = 1'b0;

    // Counting the issue register, the product is written on the third edge after acceptance
    a_mul_latency : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (!$past(flush_i, 1) && !$past(flush_i, 2))
            |-> (res.valid == $past(pkt_i.valid, MUL_STAGES - 1)));

endmodule : mul_unit

/* alu_unit.sv */
// Single-cycle integer ALU
module alu_unit (
    input  backend_pkg::issue_pkt_t pkt_i,
    result_if.producer              res
);

    import backend_pkg::*;

    data_word_t alu_result;
    logic       illegal;

    // Operand 0 is the first source, operand 1 the second
    always_comb begin : alu_compute
        alu_result = '0;
        illegal    = 1'b0;
        case (pkt_i.op)
            OP_ADD: alu_result = pkt_i.operand[0] + pkt_i.operand[1];
            OP_SUB: alu_result = pkt_i.operand[0] - pkt_i.operand[1];
            OP_AND: alu_result = pkt_i.operand[0] & pkt_i.operand[1];
            OP_OR:  alu_result = pkt_i.operand[0] | pkt_i.operand[1];
            OP_XOR: alu_result = pkt_i.operand[0] ^ pkt_i.operand[1];

            // Only the low five bits of the shift amount count
            OP_SLL: alu_result = pkt_i.operand[0] << pkt_i.operand[1][4:0];

            // The fault is carried to the head of the buffer, the result stays zero
            OP_ILLEGAL: illegal = 1'b1;

            // Multiplies never reach this unit
            default: alu_result = '0;
        endcase
    end : alu_compute

    // The result lands in the buffer on the edge after acceptance
    assign res.valid     = pkt_i.valid;
    assign res.tag       = pkt_i.tag;
    assign res.result    = alu_result;
    assign res.exception = illegal;

endmodule : alu_unit

/* issue_stage.sv */
// Operand forwarding and issue register
module issue_stage (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          flush_i,
    input  logic                          issue_valid_i,
    input  backend_pkg::op_t              issue_op_i,
    input  backend_pkg::reg_addr_t [1:0]  reg_src_i,
    input  backend_pkg::data_word_t [1:0] operand_i,
    input  logic [1:0]                    rob_fwd_hit_i,
    input  logic [1:0]                    rob_fwd_done_i,
    input  backend_pkg::data_word_t [1:0] rob_fwd_data_i,
    input  logic                          rob_full_i,
    input  backend_pkg::rob_tag_t         alloc_tag_i,
    output backend_pkg::reg_addr_t [1:0]  fwd_src_o,
    output logic                          accept_o,
    output logic                          stall_o,
    output backend_pkg::issue_pkt_t       alu_pkt_o,
    output backend_pkg::issue_pkt_t       mul_pkt_o
);

    import backend_pkg::*;

    data_word_t [1:0] src_data;
    logic [1:0]       src_pending;
    issue_pkt_t       pkt_q;

    // ============================================================
    // Forwarding and hazard detection
    // ============================================================

    // The buffer does the search, this stage only asks for both sources
    assign fwd_src_o = reg_src_i;

    // A finished in-flight producer wins over the committed register file value
    always_comb begin : operand_select
        for (int i = 0; i < 2; i++) begin
            src_pending[i] = rob_fwd_hit_i[i] & ~rob_fwd_done_i[i];
            src_data[i] = (rob_fwd_hit_i[i] & rob_fwd_done_i[i]) ? rob_fwd_data_i[i]
                                                                : operand_i[i];
        end
    end : operand_select

    // Hold issue while there is no free entry or a needed value is still being computed
    assign stall_o  = rob_full_i | (|src_pending);
    assign accept_o = issue_valid_i & ~stall_o;

    // ============================================================
    // Issue register
    // ============================================================

    // An instruction offered during a flush is younger than the exception and is dropped
    always_ff @(posedge clk_i) begin : issue_register
        if (!rst_n_i || flush_i) begin
            pkt_q.valid <= 1'b0;
        end else begin
            pkt_q.valid <= accept_o;
            if (accept_o) begin
                pkt_q.op      <= issue_op_i;
                pkt_q.operand <= src_data;
                pkt_q.tag     <= alloc_tag_i;
            end
        end
    end : issue_register

    // Multiplies go to the pipelined unit, everything else to the ALU
    always_comb begin : unit_steer
        alu_pkt_o       = pkt_q;
        mul_pkt_o       = pkt_q;
        alu_pkt_o.valid = pkt_q.valid & (pkt_q.op != OP_MUL);
        mul_pkt_o.valid = pkt_q.valid & (pkt_q.op == OP_MUL);
    end : unit_steer

endmodule : issue_stage

/* result_if.sv */
// Execution unit result channel
interface result_if;

    import backend_pkg::*;

    // Strobe that writes one finished result into the entry named by tag
    logic       valid;
    rob_tag_t   tag;
    data_word_t result;

    // Set when the operation itself was illegal
    logic       exception;

    // Driven by one execution unit
    modport producer (output valid, tag, result, exception);

    // Sampled by the reorder buffer, which never pushes back
    modport consumer (input valid, tag, result, exception);

endinterface : result_if

/* backend_pkg.sv */
// Back end shared definitions
package backend_pkg;

    // ============================================================
    // Widths and sizes
    // ============================================================

    // Width of every operand, result and instruction address
    localparam int unsigned XLEN = 32;

    // Number of instructions that can be in flight at once
    localparam int unsigned ROB_DEPTH = 8;

    // Multiplier latency, counted in edges from the accepting edge to the buffer write
    localparam int unsigned MUL_STAGES = 3;

    typedef logic [XLEN-1:0] data_word_t;

    // Register 0 always reads as zero and never has a producer in flight
    typedef logic [4:0] reg_addr_t;

    // A tag is simply the index of the buffer entry allocated at issue
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_tag_t;

    // ============================================================
    // Operations and pipeline records
    // ============================================================

    typedef enum logic [2:0] {
        OP_ADD     = 3'b000,
        OP_SUB     = 3'b001,
        OP_AND     = 3'b010,
        OP_OR      = 3'b011,
        OP_XOR     = 3'b100,
        OP_SLL     = 3'b101,
        OP_MUL     = 3'b110,
        OP_ILLEGAL = 3'b111
    } op_t;

    typedef struct packed {
        logic       valid;
        logic       done;
        reg_addr_t  reg_dest;
        data_word_t result;
        logic       exception;
        data_word_t instr_addr;
    } rob_entry_t;

    typedef struct packed {
        logic             valid;
        op_t              op;
        data_word_t [1:0] operand;
        rob_tag_t         tag;
    } issue_pkt_t;

endpackage : backend_pkg
